/* files.f */
priv_pkg.sv
priv_int_ex_handler.sv
priv_csr_file.sv
priv_trap_unit.sv
tb_clock_gen.sv
priv_trap_unit_checker.sv
priv_trap_unit_tb.sv

/* priv_csr_file.sv */
/*
 * Machine CSRs touched by traps plus the privilege register.
 * Handler updates win over a software write to the same register.
 * Unknown addresses ignore writes and read zero. Reserved bits read zero.
 */
`timescale 1ns/100ps

module priv_csr_file import priv_pkg::*; (
    input  logic       CLK,
    input  logic       arst_n,
    input  csr_next_t  nxt,
    input  csr_addr_t  csr_addr,
    input  logic       csr_wen,
    input  word_t      csr_wdata,
    output word_t      csr_rdata,
    output csr_curr_t  curr,
    output word_t      mepc_out
);

    mstatus_t    mstatus, mstatus_d;
    mie_t        mie, mie_d;
    mip_t        mip, mip_d;
    mcause_t     mcause, mcause_d;
    word_t       mepc, mepc_d;
    word_t       mtval, mtval_d;
    priv_level_t priv, priv_d;

    logic wr_mstatus;
    logic wr_mie;
    logic wr_mip;
    logic wr_mcause;
    logic wr_mepc;
    logic wr_mtval;

    // software write decode
    assign wr_mstatus = csr_wen && (csr_addr == CSR_MSTATUS);
    assign wr_mie     = csr_wen && (csr_addr == CSR_MIE);
    assign wr_mip     = csr_wen && (csr_addr == CSR_MIP);
    assign wr_mcause  = csr_wen && (csr_addr == CSR_MCAUSE);
    assign wr_mepc    = csr_wen && (csr_addr == CSR_MEPC);
    assign wr_mtval   = csr_wen && (csr_addr == CSR_MTVAL);

    always_comb begin
        mstatus_d = mstatus;
        if (nxt.inject_mstatus) begin
            mstatus_d = mstatus_t'(nxt.next_mstatus & MSTATUS_WMASK);
        end else if (wr_mstatus) begin
            mstatus_d = mstatus_t'(csr_wdata & MSTATUS_WMASK);
        end

        priv_d = nxt.inject_mstatus ? nxt.next_priv : priv;

        mie_d = mie;
        if (wr_mie) begin
            mie_d = mie_t'(csr_wdata & MIE_WMASK);
        end

        mip_d = mip;
        if (nxt.inject_mip) begin
            mip_d = mip_t'(nxt.next_mip & MIP_MASK);
        end else if (wr_mip) begin
            // machine pending bits only move through the request lines
            mip_d = mip_t'((mip & ~MIP_SW_MASK) | (csr_wdata & MIP_SW_MASK));
        end

        mcause_d = mcause;
        if (nxt.inject_mcause) begin
            mcause_d = nxt.next_mcause;
        end else if (wr_mcause) begin
            mcause_d = mcause_t'(csr_wdata);
        end

        mepc_d = mepc;
        if (nxt.inject_mepc) begin
            mepc_d = nxt.next_mepc;
        end else if (wr_mepc) begin
            mepc_d = csr_wdata;
        end

        mtval_d = mtval;
        if (nxt.inject_mtval) begin
            mtval_d = nxt.next_mtval;
        end else if (wr_mtval) begin
            mtval_d = csr_wdata;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            mstatus <= '0;
            mie     <= '0;
            mip     <= '0;
            mcause  <= '0;
            mepc    <= '0;
            mtval   <= '0;
            priv    <= M_MODE;   // core starts in machine mode
        end else begin
            mstatus <= mstatus_d;
            mie     <= mie_d;
            mip     <= mip_d;
            mcause  <= mcause_d;
            mepc    <= mepc_d;
            mtval   <= mtval_d;
            priv    <= priv_d;
        end
    end

    // read port sees registered state only
    always_comb begin
        case (csr_addr)
            CSR_MSTATUS: csr_rdata = word_t'(mstatus);
            CSR_MIE:     csr_rdata = word_t'(mie);
            CSR_MIP:     csr_rdata = word_t'(mip);
            CSR_MCAUSE:  csr_rdata = word_t'(mcause);
            CSR_MEPC:    csr_rdata = mepc;
            CSR_MTVAL:   csr_rdata = mtval;
            default:     csr_rdata = '0;
        endcase
    end

    always_comb begin
        curr.curr_mstatus = mstatus;
        curr.curr_mie     = mie;
        curr.curr_mip     = mip;
        curr.curr_mtval   = mtval;
        curr.curr_priv    = priv;
    end

    assign mepc_out = mepc;  // return target for mret

endmodule

/* priv_int_ex_handler.sv */
/*
 * Combinational trap decision. trap follows ex_flags in the same cycle.
 * Interrupts fire only from enabled pending bits in mip, never from the
 * raw request lines. The pipeline has to squash the trapping instruction.
 */
`timescale 1ns/100ps

module priv_int_ex_handler import priv_pkg::*; (
    input  csr_curr_t  curr,
    input  ex_flags_t  ex_flags,
    input  int_lines_t int_set,
    input  int_lines_t int_clear,
    input  word_t      epc,
    input  word_t      tval,
    input  logic       mret,
    output csr_next_t  nxt,
    output logic       trap
);

    ex_code_t  ex_src;
    int_code_t int_src;
    logic      exception;
    logic      int_fire;
    logic      tval_ex;     // exception reports a faulting value
    mip_t      pend;        // pending and enabled
    mip_t      mip_upd;

    // highest priority exception wins
    always_comb begin
        exception = 1'b1;
        ex_src    = INSN_MAL;
        if (ex_flags.breakpoint) begin
            ex_src = BREAKPOINT;
        end else if (ex_flags.fault_insn_page) begin
            ex_src = INSN_PAGE;
        end else if (ex_flags.fault_insn_access) begin
            ex_src = INSN_ACCESS;
        end else if (ex_flags.illegal_insn) begin
            ex_src = ILLEGAL_INSN;
        end else if (ex_flags.mal_insn) begin
            ex_src = INSN_MAL;
        end else if (ex_flags.env_u) begin
            ex_src = ENV_CALL_U;
        end else if (ex_flags.env_s) begin
            ex_src = ENV_CALL_S;
        end else if (ex_flags.env_m) begin
            ex_src = ENV_CALL_M;
        end else if (ex_flags.mal_s) begin
            ex_src = S_ADDR_MAL;
        end else if (ex_flags.mal_l) begin
            ex_src = L_ADDR_MAL;
        end else if (ex_flags.fault_store_page) begin
            ex_src = STORE_PAGE;
        end else if (ex_flags.fault_load_page) begin
            ex_src = LOAD_PAGE;
        end else if (ex_flags.fault_s) begin
            ex_src = S_FAULT;
        end else if (ex_flags.fault_l) begin
            ex_src = L_FAULT;
        end else begin
            exception = 1'b0;
        end
    end

    // only the winning cause decides whether tval is kept
    always_comb begin
        case (ex_src)
            BREAKPOINT, L_ADDR_MAL, L_FAULT, S_ADDR_MAL, S_FAULT,
            ILLEGAL_INSN, INSN_ACCESS, INSN_MAL: tval_ex = exception;
            default:                             tval_ex = 1'b0;
        endcase
    end

    // enable and pending share bit positions
    assign pend = mip_t'(curr.curr_mip & curr.curr_mie);

    assign int_fire = curr.curr_mstatus.mie & (pend.meip | pend.msip | pend.mtip);

    always_comb begin
        int_src = TIMER_INT_M;
        if (pend.meip) begin
            int_src = EXT_INT_M;
        end else if (pend.msip) begin
            int_src = SOFT_INT_M;
        end
    end

    assign trap = exception | int_fire;

    // set beats clear on the same line
    always_comb begin
        mip_upd      = curr.curr_mip;
        mip_upd.meip = int_set.ext_m   | (curr.curr_mip.meip & ~int_clear.ext_m);
        mip_upd.msip = int_set.soft_m  | (curr.curr_mip.msip & ~int_clear.soft_m);
        mip_upd.mtip = int_set.timer_m | (curr.curr_mip.mtip & ~int_clear.timer_m);
        mip_upd.seip = int_set.ext_s   | (curr.curr_mip.seip & ~int_clear.ext_s);
        mip_upd.ssip = int_set.soft_s  | (curr.curr_mip.ssip & ~int_clear.soft_s);
        mip_upd.stip = int_set.timer_s | (curr.curr_mip.stip & ~int_clear.timer_s);
    end

    always_comb begin
        nxt = '0;

        nxt.inject_mcause          = trap;
        nxt.next_mcause.interrupt  = ~exception;  // exception always wins
        nxt.next_mcause.cause      = exception ? 31'(ex_src) : 31'(int_src);

        nxt.inject_mepc = trap;
        nxt.next_mepc   = epc;

        nxt.inject_mtval = trap;
        nxt.next_mtval   = curr.curr_mtval;
        if (trap) begin
            nxt.next_mtval = (exception && tval_ex) ? tval : '0;
        end

        nxt.inject_mip = (|int_set) | (|int_clear);
        nxt.next_mip   = mip_upd;

        // trap entry and mret both move the privilege level
        nxt.inject_mstatus = trap | mret;
        nxt.next_mstatus   = curr.curr_mstatus;
        nxt.next_priv      = curr.curr_priv;
        if (trap) begin
            nxt.next_mstatus.mpie = curr.curr_mstatus.mie;
            nxt.next_mstatus.mie  = 1'b0;
            nxt.next_mstatus.mpp  = curr.curr_priv;
            nxt.next_priv         = M_MODE;
        end else if (mret) begin
            nxt.next_mstatus.mie  = curr.curr_mstatus.mpie;
            nxt.next_mstatus.mpie = 1'b0;
            nxt.next_mstatus.mpp  = U_MODE;    // least privileged mode
            if (curr.curr_mstatus.mpp != M_MODE) begin
                nxt.next_mstatus.mprv = 1'b0;
            end
            nxt.next_priv = curr.curr_mstatus.mpp;
        end
    end

endmodule

/* priv_pkg.sv */
/*
 * Shared types for the RV32 machine-mode trap logic. XLEN is fixed at 32.
 * Only the M-mode CSRs that traps touch are described. There are no
 * supervisor delegation or debug mode fields.
 */
package priv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MIE     = 12'h304;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;
    localparam csr_addr_t CSR_MTVAL   = 12'h343;
    localparam csr_addr_t CSR_MIP     = 12'h344;

    localparam word_t MSTATUS_WMASK = 32'h0002_1888; // mprv, mpp, mpie, mie
    localparam word_t MIE_WMASK     = 32'h0000_0aaa; // six enable bits
    localparam word_t MIP_MASK      = 32'h0000_0aaa; // six pending bits
    localparam word_t MIP_SW_MASK   = 32'h0000_0222; // ssip, stip, seip from software

    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        S_MODE = 2'd1,
        M_MODE = 2'd3
    } priv_level_t;

    typedef enum logic [30:0] {
        INSN_MAL     = 31'd0,
        INSN_ACCESS  = 31'd1,
        ILLEGAL_INSN = 31'd2,
        BREAKPOINT   = 31'd3,
        L_ADDR_MAL   = 31'd4,
        L_FAULT      = 31'd5,
        S_ADDR_MAL   = 31'd6,
        S_FAULT      = 31'd7,
        ENV_CALL_U   = 31'd8,
        ENV_CALL_S   = 31'd9,
        ENV_CALL_M   = 31'd11,
        INSN_PAGE    = 31'd12,
        LOAD_PAGE    = 31'd13,
        STORE_PAGE   = 31'd15
    } ex_code_t;

    typedef enum logic [30:0] {
        SOFT_INT_S  = 31'd1,
        SOFT_INT_M  = 31'd3,
        TIMER_INT_S = 31'd5,
        TIMER_INT_M = 31'd7,
        EXT_INT_S   = 31'd9,
        EXT_INT_M   = 31'd11
    } int_code_t;

    typedef struct packed {
        logic [31:18] res_31_18;
        logic         mprv;
        logic [16:13] res_16_13;
        priv_level_t  mpp;
        logic [10:8]  res_10_8;
        logic         mpie;
        logic [6:4]   res_6_4;
        logic         mie;
        logic [2:0]   res_2_0;
    } mstatus_t;

    typedef struct packed {
        logic [31:12] res_31_12;
        logic meip;
        logic res_10;
        logic seip;
        logic res_8;
        logic mtip;
        logic res_6;
        logic stip;
        logic res_4;
        logic msip;
        logic res_2;
        logic ssip;
        logic res_0;
    } mip_t;

    typedef struct packed {
        logic [31:12] res_31_12;
        logic meie;
        logic res_10;
        logic seie;
        logic res_8;
        logic mtie;
        logic res_6;
        logic stie;
        logic res_4;
        logic msie;
        logic res_2;
        logic ssie;
        logic res_0;
    } mie_t;

    typedef struct packed {
        logic        interrupt;
        logic [30:0] cause;
    } mcause_t;

    // order of fields is the exception priority, highest first
    typedef struct packed {
        logic breakpoint;
        logic fault_insn_page;
        logic fault_insn_access;
        logic illegal_insn;
        logic mal_insn;
        logic env_u;
        logic env_s;
        logic env_m;
        logic mal_s;
        logic mal_l;
        logic fault_store_page;
        logic fault_load_page;
        logic fault_s;
        logic fault_l;
    } ex_flags_t;

    typedef struct packed {
        logic ext_m;
        logic soft_m;
        logic timer_m;
        logic ext_s;
        logic soft_s;
        logic timer_s;
    } int_lines_t;

    typedef struct packed {
        mstatus_t    next_mstatus;
        mip_t        next_mip;
        mcause_t     next_mcause;
        word_t       next_mepc;
        word_t       next_mtval;
        priv_level_t next_priv;    // loaded together with mstatus
        logic        inject_mstatus;
        logic        inject_mip;
        logic        inject_mcause;
        logic        inject_mepc;
        logic        inject_mtval;
    } csr_next_t;

    typedef struct packed {
        mstatus_t    curr_mstatus;
        mie_t        curr_mie;
        mip_t        curr_mip;
        word_t       curr_mtval;
        priv_level_t curr_priv;
    } csr_curr_t;

endpackage

/* priv_trap_unit.sv */
/*
 * Machine-mode trap unit top. All inputs are strobes or levels with no
 * handshake. trap is combinational from ex_flags and registered CSR state.
 * CSR state changes are visible from the cycle after the update.
 */
`timescale 1ns/100ps

module priv_trap_unit import priv_pkg::*; (
    input  logic        CLK,
    input  logic        arst_n,
    input  ex_flags_t   ex_flags,
    input  int_lines_t  int_set,     // request pulses
    input  int_lines_t  int_clear,   // clear pulses
    input  word_t       epc,
    input  word_t       tval,
    input  logic        mret,
    input  csr_addr_t   csr_addr,
    input  logic        csr_wen,
    input  word_t       csr_wdata,
    output word_t       csr_rdata,
    output logic        trap,
    output word_t       mepc_out,
    output priv_level_t priv
);

    csr_curr_t curr;
    csr_next_t nxt;

    priv_int_ex_handler u_handler (
        .curr      (curr),
        .ex_flags  (ex_flags),
        .int_set   (int_set),
        .int_clear (int_clear),
        .epc       (epc),
        .tval      (tval),
        .mret      (mret),
        .nxt       (nxt),
        .trap      (trap)
    );

    priv_csr_file u_csr_file (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .nxt       (nxt),
        .csr_addr  (csr_addr),
        .csr_wen   (csr_wen),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .curr      (curr),
        .mepc_out  (mepc_out)
    );

    assign priv = curr.curr_priv;

endmodule

/* priv_trap_unit_checker.sv */
/*
 * Concurrent checks on the trap unit top, attached with bind.
 * fail_count holds the number of failed assertions for the run summary.
 */
`timescale 1ns/100ps

module priv_trap_unit_checker import priv_pkg::*; (
    input logic        CLK,
    input logic        arst_n,
    input logic        trap,
    input priv_level_t priv,
    input ex_flags_t   ex_flags,
    input logic        mstatus_mie
);

    int unsigned fail_count = 0;

    // no trap while reset is held
    trap_low_in_reset: assert property (@(posedge CLK) !arst_n |-> !trap)
        else begin
            fail_count++;
            $error("trap is high while arst_n is low");
        end

    trap_enters_m_mode: assert property (@(posedge CLK) disable iff (!arst_n)
        trap |=> (priv == M_MODE))
        else begin
            fail_count++;
            $error("priv is not M_MODE in the cycle after a trap");
        end

    // interrupts are globally masked and no exception is flagged
    no_trap_when_masked: assert property (@(posedge CLK) disable iff (!arst_n)
        (!mstatus_mie && ex_flags == '0) |-> !trap)
        else begin
            fail_count++;
            $error("trap raised with mstatus.mie and all ex_flags clear");
        end

    trap_clears_mie: assert property (@(posedge CLK) disable iff (!arst_n)
        trap |=> !mstatus_mie)
        else begin
            fail_count++;
            $error("mstatus.mie still set in the cycle after a trap");
        end

endmodule

/* priv_trap_unit_tb.sv */
/*
 * Testbench for the machine-mode trap unit. A CSR model follows the trap,
 * mret, mip and software write rules. Every cycle trap, priv, mepc_out and
 * the CSR read port are compared with the model. Inputs change on falling edges.
 */
`timescale 1ns/100ps

module priv_trap_unit_tb import priv_pkg::*; ();

    typedef struct packed {
        ex_flags_t  ex_flags;
        int_lines_t int_set;
        int_lines_t int_clear;
        word_t      epc;
        word_t      tval;
        logic       mret;
        logic       csr_wen;
        csr_addr_t  csr_addr;
        word_t      csr_wdata;
    } stim_t;

    logic        CLK;
    logic        arst_n;
    stim_t       s;          // every DUT input
    word_t       csr_rdata;
    logic        trap;
    word_t       mepc_out;
    priv_level_t priv;

    word_t       m_mstatus, m_mie, m_mip, m_mcause, m_mepc, m_mtval;
    priv_level_t m_priv;
    logic [31:0] lfsr = 32'he019;
    int          checks = 0;
    int          errors = 0;
    logic        released;

    // cause code per ex_flags bit, bit 0 is fault_l and bit 13 is breakpoint
    logic [30:0] cause_of_bit [14] = '{L_FAULT, S_FAULT, LOAD_PAGE, STORE_PAGE, L_ADDR_MAL,
        S_ADDR_MAL, ENV_CALL_M, ENV_CALL_S, ENV_CALL_U, INSN_MAL, ILLEGAL_INSN, INSN_ACCESS,
        INSN_PAGE, BREAKPOINT};
    logic [13:0] tval_flags = 14'h2e33;  // flags that report a faulting value
    csr_addr_t   read_addrs [7] = '{CSR_MSTATUS, CSR_MIE, CSR_MIP, CSR_MCAUSE, CSR_MEPC,
        CSR_MTVAL, 12'h7c0};

    tb_clock_gen u_clk (
        .CLK    (CLK),
        .arst_n (arst_n)
    );

    priv_trap_unit u_dut (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .ex_flags  (s.ex_flags),
        .int_set   (s.int_set),
        .int_clear (s.int_clear),
        .epc       (s.epc),
        .tval      (s.tval),
        .mret      (s.mret),
        .csr_addr  (s.csr_addr),
        .csr_wen   (s.csr_wen),
        .csr_wdata (s.csr_wdata),
        .csr_rdata (csr_rdata),
        .trap      (trap),
        .mepc_out  (mepc_out),
        .priv      (priv)
    );

    bind priv_trap_unit priv_trap_unit_checker u_checker (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .trap        (trap),
        .priv        (priv),
        .ex_flags    (ex_flags),
        .mstatus_mie (curr.curr_mstatus.mie)
    );

    // Fibonacci LFSR with taps 32 22 2 1, one step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [30:0] ex_cause(input ex_flags_t f);
        logic [30:0] c;
        c = '0;
        for (int i = 0; i < 14; i++) begin
            if (f[i]) begin
                c = cause_of_bit[i];  // higher bits overwrite, so priority holds
            end
        end
        return c;
    endfunction

    // the highest priority flag alone decides whether tval is recorded
    function automatic logic keeps_tval(input ex_flags_t f);
        logic t;
        t = 1'b0;
        for (int i = 0; i < 14; i++) begin
            if (f[i]) begin
                t = tval_flags[i];
            end
        end
        return t;
    endfunction

    // request lines placed on their mip bit positions
    function automatic word_t line_bits(input int_lines_t l);
        return {20'd0, l.ext_m, 1'b0, l.ext_s, 1'b0, l.timer_m, 1'b0, l.timer_s, 1'b0,
                l.soft_m, 1'b0, l.soft_s, 1'b0};
    endfunction

    function automatic word_t model_read(input csr_addr_t a);
        case (a)
            CSR_MSTATUS: return m_mstatus;
            CSR_MIE:     return m_mie;
            CSR_MIP:     return m_mip;
            CSR_MCAUSE:  return m_mcause;
            CSR_MEPC:    return m_mepc;
            CSR_MTVAL:   return m_mtval;
            default:     return '0;
        endcase
    endfunction

    task automatic compare(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // one cycle of stimulus, output checks, then the model moves to the next edge
    task automatic run_cycle(input stim_t st);
        word_t pend;
        logic  exc;
        logic  take;
        @(negedge CLK);
        s = st;
        #1;
        exc  = |st.ex_flags;
        pend = m_mip & m_mie & 32'h0000_0888;  // machine lines only
        take = exc || (m_mstatus[3] && pend != '0);
        compare("trap", word_t'(trap), word_t'(take));
        compare("priv", word_t'(priv), word_t'(m_priv));
        compare("mepc_out", mepc_out, m_mepc);
        compare("csr_rdata", csr_rdata, model_read(st.csr_addr));
        if (take) begin
            if (exc) begin
                m_mcause = {1'b0, ex_cause(st.ex_flags)};
            end else if (pend[11]) begin
                m_mcause = {1'b1, 31'(EXT_INT_M)};
            end else if (pend[3]) begin
                m_mcause = {1'b1, 31'(SOFT_INT_M)};
            end else begin
                m_mcause = {1'b1, 31'(TIMER_INT_M)};
            end
            m_mtval          = (exc && keeps_tval(st.ex_flags)) ? st.tval : '0;
            m_mepc           = st.epc;
            m_mstatus[7]     = m_mstatus[3];
            m_mstatus[3]     = 1'b0;
            m_mstatus[12:11] = m_priv;
            m_priv           = M_MODE;
        end else if (st.mret) begin
            m_priv           = priv_level_t'(m_mstatus[12:11]);
            m_mstatus[3]     = m_mstatus[7];
            m_mstatus[7]     = 1'b0;
            m_mstatus[12:11] = U_MODE;
            if (m_priv != M_MODE) begin
                m_mstatus[17] = 1'b0;
            end
        end
        if (st.csr_wen && !take) begin
            case (st.csr_addr)
                CSR_MCAUSE:  m_mcause = st.csr_wdata;
                CSR_MEPC:    m_mepc   = st.csr_wdata;
                CSR_MTVAL:   m_mtval  = st.csr_wdata;
                CSR_MSTATUS: begin
                    if (!st.mret) begin
                        m_mstatus = st.csr_wdata & MSTATUS_WMASK;
                    end
                end
                default: ;
            endcase
        end
        if (st.csr_wen && st.csr_addr == CSR_MIE) begin
            m_mie = st.csr_wdata & MIE_WMASK;
        end
        if (|{st.int_set, st.int_clear}) begin
            m_mip = line_bits(st.int_set) | (m_mip & ~line_bits(st.int_clear));
        end else if (st.csr_wen && st.csr_addr == CSR_MIP) begin
            m_mip = (m_mip & ~MIP_SW_MASK) | (st.csr_wdata & MIP_SW_MASK);
        end
    endtask

    task automatic read_all();
        stim_t st;
        foreach (read_addrs[i]) begin
            st          = '0;
            st.csr_addr = read_addrs[i];
            run_cycle(st);
        end
    endtask

    task automatic write_csr(input csr_addr_t a, input word_t d);
        stim_t st;
        st           = '0;
        st.csr_wen   = 1'b1;
        st.csr_addr  = a;
        st.csr_wdata = d;
        run_cycle(st);
    endtask

    task automatic pulse_lines(input int_lines_t set, input int_lines_t clr);
        stim_t st;
        st           = '0;
        st.int_set   = set;
        st.int_clear = clr;
        run_cycle(st);
    endtask

    task automatic do_mret();
        stim_t st;
        st      = '0;
        st.mret = 1'b1;
        run_cycle(st);
    endtask

    task automatic run_tests();
        stim_t st;
        word_t r;
        read_all();                          // reset values
        repeat (16) begin
            st = '0;
            r  = rand_bits(14);
            st.ex_flags = r[13:0];
            if (st.ex_flags == '0) begin
                st.ex_flags.fault_l = 1'b1;
            end
            st.epc  = rand_bits(32);
            st.tval = rand_bits(32);
            run_cycle(st);
            read_all();
        end
        // drop to U mode with mie set, trap, then return
        write_csr(CSR_MSTATUS, 32'h0000_0080);
        do_mret();
        st = '0;
        st.ex_flags.env_u = 1'b1;
        st.epc = 32'h0000_1000;
        run_cycle(st);
        read_all();
        do_mret();
        read_all();
        // timer pulse traps one cycle later
        write_csr(CSR_MIE, 32'h0000_0888);
        pulse_lines(6'b001000, '0);
        run_cycle('0);
        read_all();
        pulse_lines('0, 6'b001000);
        pulse_lines(6'b110000, '0);          // ext and soft while masked
        read_all();
        write_csr(CSR_MSTATUS, 32'h0000_0008);
        read_all();
        pulse_lines('0, 6'b110000);
        // set beats clear, then clear alone
        pulse_lines(6'b001000, 6'b001000);
        read_all();
        pulse_lines('0, 6'b001000);
        read_all();
        write_csr(CSR_MIE, 32'h0000_0aaa);
        write_csr(CSR_MSTATUS, 32'h0000_0008);
        pulse_lines(6'b000111, '0);          // supervisor lines never trap
        read_all();
        write_csr(CSR_MIP, 32'h0000_0000);
        read_all();
        // trap value wins over a write to mcause
        st = '0;
        st.ex_flags.illegal_insn = 1'b1;
        st.epc       = 32'h0000_2000;
        st.tval      = 32'hdead_beef;
        st.csr_wen   = 1'b1;
        st.csr_addr  = CSR_MCAUSE;
        st.csr_wdata = 32'h8000_00ff;
        run_cycle(st);
        read_all();
        write_csr(CSR_MSTATUS, 32'hffff_ffff);
        write_csr(CSR_MIE, 32'hffff_ffff);
        write_csr(CSR_MEPC, 32'h1234_5678);
        write_csr(CSR_MTVAL, 32'hcafe_f00d);
        write_csr(12'h7c0, 32'hffff_ffff);   // unknown address
        read_all();
        do_mret();                           // mpp is M so mprv stays
        read_all();
    endtask

    initial begin
        int n;
        s         = '0;
        m_mstatus = '0;
        m_mie     = '0;
        m_mip     = '0;
        m_mcause  = '0;
        m_mepc    = '0;
        m_mtval   = '0;
        m_priv    = M_MODE;
        n = 0;
        while (arst_n !== 1'b1 && n < 20) begin
            @(posedge CLK);
            n++;
        end
        released = (arst_n === 1'b1);
        if (released) begin
            run_tests();
        end else begin
            $display("Timeout: reset was never released");
        end
        $display("checks: %0d  mismatches: %0d  assertion failures: %0d",
                 checks, errors, u_dut.u_checker.fail_count);
        if (released && errors == 0 && u_dut.u_checker.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
/*
 * Testbench clock and reset source. 10 ns period.
 * arst_n is held low for the first 3 cycles and released on a falling edge.
 */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic CLK,
    output logic arst_n
);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;  // release away from the active edge
    end

endmodule
